// ==== src/sense_pkg.sv ====
// sensor front end constants, channel codes follow the A2D mux numbering
// CH_SEQ is packed with index 0 holding the first channel of a loop
package sense_pkg;

    typedef logic [2:0] chan_t;

    localparam int NUM_CH = 6;
    localparam logic [NUM_CH-1:0][2:0] CH_SEQ = {3'd7, 3'd3, 3'd2, 3'd4, 3'd0, 3'd1};

    localparam int SETTLE_CYCLES = 4096;  // emitter settle before first conversion
    localparam int GAP_CYCLES    = 32;
    localparam int TMR_WIDTH     = 13;    // must hold SETTLE_CYCLES + 1

    localparam int PWM_WIDTH = 8;
    localparam logic [PWM_WIDTH-1:0] PWM_OFF_COUNT = 8'h8c;

    localparam int A2D_WIDTH = 12;

    typedef enum logic [1:0] {inner, middle, outer} pair_t;

    // codes 5 and 6 are never selected
    function automatic pair_t pair_of(input chan_t ch);
        case (ch)
            3'd1, 3'd0: return inner;
            3'd4, 3'd2: return middle;
            default:    return outer;
        endcase
    endfunction

endpackage

// ==== src/pi_pkg.sv ====
// datapath widths and gains of the steering loop
// gains are unsigned, products are arithmetically shifted back down
package pi_pkg;

    localparam int DATA_WIDTH  = 12;
    localparam int ACC_WIDTH   = 16;
    localparam int MOTOR_WIDTH = 11;

    typedef logic signed [DATA_WIDTH-1:0] err_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;

    localparam int GAIN_WIDTH = 14;
    localparam int PROD_WIDTH = DATA_WIDTH + GAIN_WIDTH + 1;  // signed operand times 0-extended gain

    localparam logic [GAIN_WIDTH-1:0] P_TERM = 14'h3680;
    localparam int P_SHIFT = 13;
    localparam logic [DATA_WIDTH-1:0] I_TERM = 12'h500;
    localparam int I_SHIFT = 11;

    localparam int INT_DECIM = 4;     // loops per integrator update
    localparam err_t FWD_CEIL = 12'sh700;

    localparam err_t ERR_MAX = 12'sh7ff;
    localparam err_t ERR_MIN = 12'sh800;

    function automatic err_t sat12(input acc_t val);
        if (val > acc_t'(ERR_MAX))
            return ERR_MAX;
        else if (val < acc_t'(ERR_MIN))
            return ERR_MIN;
        return val[DATA_WIDTH-1:0];
    endfunction

endpackage

// ==== src/sample_if.sv ====
// one qualified sensor reading, dummy conversions never show up here
// weight_shift is 0, 1 or 2 for inner, middle, outer
`timescale 1ns/1ps

interface sample_if import sense_pkg::*; ();

    logic                 valid;   // single cycle strobe
    logic [A2D_WIDTH-1:0] data;
    logic [1:0]           weight_shift;
    logic                 negate;  // second channel of a pair
    logic                 clear;   // loop start
    logic                 last;    // with valid on channel 7

    modport src (output valid, data, weight_shift, negate, clear, last);
    modport dst (input valid, data, weight_shift, negate, clear, last);

endinterface

// ==== src/sensor_seq.sv ====
// walks the six channels, one dummy then one real conversion per channel
// a conversion is done once cnv_cmplt went low after the strobe and is high again
// a loop started with go high always runs to channel 7
`timescale 1ns/1ps

module sensor_seq
    import sense_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 go,
    output logic                 strt_cnv,
    input  logic                 cnv_cmplt,
    input  logic [A2D_WIDTH-1:0] A2D_res,
    output chan_t                chnnl,
    output logic                 pwm_on,
    output logic                 loop_done,
    sample_if.src                smp
);

    typedef enum logic [2:0] {
        st_idle,
        st_settle,
        st_dummy,
        st_gap,
        st_real,
        st_sample,
        st_next
    } state_t;

    state_t               state;
    state_t               next_state;
    logic [TMR_WIDTH-1:0] timer;
    logic [2:0]           ch_idx;      // position in CH_SEQ
    logic                 low_seen;
    logic                 real_next;   // gap leads into the real conversion
    logic [A2D_WIDTH-1:0] res_q;
    logic                 cnv_done;
    logic                 start_req;
    logic                 second_ch;
    logic                 last_ch;

    assign chnnl     = CH_SEQ[ch_idx];
    assign second_ch = ch_idx[0];
    assign last_ch   = (ch_idx == 3'(NUM_CH - 1));
    assign cnv_done  = low_seen & cnv_cmplt;

    always_comb begin
        next_state = state;
        start_req  = 1'b0;
        case (state)
            st_idle:
                if (go)
                    next_state = st_settle;
            st_settle:
                // emitter lights a cycle after pwm_on, strobe is registered
                if (timer == TMR_WIDTH'(SETTLE_CYCLES + 1)) begin
                    next_state = st_dummy;
                    start_req  = 1'b1;
                end
            st_dummy:
                if (cnv_done)
                    next_state = st_gap;
            st_gap:
                if (timer == TMR_WIDTH'(GAP_CYCLES - 1)) begin
                    next_state = real_next ? st_real : st_dummy;
                    start_req  = 1'b1;
                end
            st_real:
                if (cnv_done)
                    next_state = st_sample;
            st_sample:
                next_state = st_next;
            st_next:
                if (last_ch)
                    next_state = st_idle;
                else if (second_ch)
                    next_state = st_settle;  // new pair
                else
                    next_state = st_gap;
            default:
                next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            timer     <= '0;
            ch_idx    <= '0;
            low_seen  <= 1'b0;
            real_next <= 1'b0;
            strt_cnv  <= 1'b0;
            pwm_on    <= 1'b0;
            loop_done <= 1'b0;
        end else begin
            state     <= next_state;
            strt_cnv  <= start_req;
            loop_done <= (state == st_next) && last_ch;

            if (state != next_state)
                timer <= '0;
            else if (state == st_settle || state == st_gap)
                timer <= timer + 1'b1;

            if (start_req)
                low_seen <= 1'b0;
            else if (!cnv_cmplt)
                low_seen <= 1'b1;

            if (state == st_dummy && cnv_done)
                real_next <= 1'b1;
            else if (state == st_real)
                real_next <= 1'b0;

            if (next_state == st_settle && state != st_settle)
                pwm_on <= 1'b1;
            else if (state == st_real && cnv_done && second_ch)
                pwm_on <= 1'b0;

            if (state == st_next)
                ch_idx <= last_ch ? 3'd0 : ch_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_real && cnv_done)
            res_q <= A2D_res;
    end

    assign smp.valid        = (state == st_sample);
    assign smp.data         = res_q;
    assign smp.weight_shift = pair_of(chnnl);  // enum order gives the shift
    assign smp.negate       = second_ch;
    assign smp.clear        = (state == st_idle) && go;
    assign smp.last         = (state == st_sample) && last_ch;

    // converter only drops its completion while a conversion is pending
    a_cmplt_falls_in_cnv: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cnv_cmplt) |-> state inside {st_dummy, st_real});

endmodule

// ==== src/ir_pwm.sv ====
// emitter pulse for the lit pair, starts high on pwm_on rise
// counter is cleared whenever pwm_on is low
`timescale 1ns/1ps

module ir_pwm
    import sense_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  pwm_on,
    input  chan_t chnnl,
    output logic  IR_in_en,
    output logic  IR_mid_en,
    output logic  IR_out_en
);

    logic [PWM_WIDTH-1:0] pwm_cnt;
    logic                 pwm_on_q;
    logic                 pulse;
    pair_t                pair;

    assign pair = pair_of(chnnl);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt  <= '0;
            pwm_on_q <= 1'b0;
            pulse    <= 1'b0;
        end else begin
            pwm_on_q <= pwm_on;
            pwm_cnt  <= pwm_on ? pwm_cnt + 1'b1 : '0;
            if (!pwm_on)
                pulse <= 1'b0;
            else if (!pwm_on_q || &pwm_cnt)  // rise or wrap
                pulse <= 1'b1;
            else if (pwm_cnt == PWM_OFF_COUNT)
                pulse <= 1'b0;
        end
    end

    assign IR_in_en  = pulse && (pair == inner);
    assign IR_mid_en = pulse && (pair == middle);
    assign IR_out_en = pulse && (pair == outer);

    // lit pair never switches over while the emitter is on
    a_pair_steady_while_lit: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(pair) |-> !pulse);

endmodule

// ==== src/error_accum.sv ====
// weighted sum of one loop's readings, saturated to 12 bits on the last sample
// inner readings weigh 1, middle 2, outer 4
`timescale 1ns/1ps

module error_accum
    import sense_pkg::*;
    import pi_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    sample_if.dst      smp,
    output err_t       error,
    output logic [7:0] LEDs
);

    acc_t accum;
    acc_t term;
    acc_t sum;

    // reading is unsigned, the cast zero extends
    assign term = acc_t'(smp.data) << smp.weight_shift;
    assign sum  = smp.negate ? accum - term : accum + term;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accum <= '0;
            error <= '0;
        end else begin
            if (smp.clear)
                accum <= '0;
            else if (smp.valid)
                accum <= sum;
            if (smp.valid && smp.last)
                error <= sat12(sum);
        end
    end

    assign LEDs = error[DATA_WIDTH-1 -: 8];  // sign plus top magnitude bits

endmodule

// ==== src/pi_ctrl.sv ====
// PI step per loop, one multiplier shared by the P and I terms
// integrator and forward ramp move only on every fourth loop
// go low zeroes the ramp and the motors, the integrator is kept
`timescale 1ns/1ps

module pi_ctrl
    import pi_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   go,
    input  logic                   loop_done,
    input  err_t                   error,
    output logic [MOTOR_WIDTH-1:0] lft,
    output logic [MOTOR_WIDTH-1:0] rht
);

    typedef enum logic [2:0] {
        st_idle,
        st_p_mul,
        st_p_sat,
        st_i_mul,
        st_i_sat,
        st_out
    } step_t;

    step_t                        state;
    logic [$clog2(INT_DECIM)-1:0] loop_cnt;
    logic                         upd;
    err_t                         intgrl;
    err_t                         fwd;
    err_t                         pcomp;
    err_t                         icomp;
    err_t                         rht_reg;
    err_t                         lft_reg;
    err_t                         mul_a;
    logic signed [GAIN_WIDTH:0]   mul_b;
    logic signed [PROD_WIDTH-1:0] prod;
    logic signed [PROD_WIDTH-1:0] prod_sh;
    err_t                         comp;

    assign upd = loop_done && (&loop_cnt);  // 4th, 8th, ... loop

    assign mul_a   = (state == st_p_mul) ? error : intgrl;
    assign mul_b   = (state == st_p_mul) ? {1'b0, P_TERM} : {1'b0, GAIN_WIDTH'(I_TERM)};
    assign prod_sh = (state == st_i_sat) ? prod >>> I_SHIFT : prod >>> P_SHIFT;
    assign comp    = sat12(acc_t'(prod_sh));  // shifted product fits in 16 bits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            loop_cnt <= '0;
            intgrl   <= '0;
            fwd      <= '0;
            rht_reg  <= '0;
            lft_reg  <= '0;
        end else begin
            case (state)
                st_idle:  if (loop_done) state <= st_p_mul;
                st_p_mul: state <= st_p_sat;
                st_p_sat: state <= st_i_mul;
                st_i_mul: state <= st_i_sat;
                st_i_sat: state <= st_out;
                default:  state <= st_idle;
            endcase

            if (loop_done)
                loop_cnt <= loop_cnt + 1'b1;
            if (upd)
                intgrl <= sat12(acc_t'(intgrl) + acc_t'(error));

            if (!go)
                fwd <= '0;
            else if (upd && fwd < FWD_CEIL)
                fwd <= fwd + 1'b1;

            if (!go) begin
                rht_reg <= '0;
                lft_reg <= '0;
            end else if (state == st_out) begin
                rht_reg <= sat12(acc_t'(fwd) - acc_t'(pcomp) - acc_t'(icomp));
                lft_reg <= sat12(acc_t'(fwd) + acc_t'(pcomp) + acc_t'(icomp));
            end
        end
    end

    // multiplier and its results
    always_ff @(posedge clk) begin
        if (state == st_p_mul || state == st_i_mul)
            prod <= mul_a * mul_b;
        if (state == st_p_sat)
            pcomp <= comp;
        if (state == st_i_sat)
            icomp <= comp;
    end

    assign rht = rht_reg[DATA_WIDTH-1:1];
    assign lft = lft_reg[DATA_WIDTH-1:1];

    a_one_loop_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        loop_done |-> state == st_idle);

endmodule

// ==== src/motion_ctrl.sv ====
// line follower motion controller top, six IR sensors through an external A2D
// converter must hold cnv_cmplt high until the next strt_cnv
`timescale 1ns/1ps

module motion_ctrl
    import sense_pkg::*;
    import pi_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   go,
    output logic                   strt_cnv,
    output logic [2:0]             chnnl,
    input  logic                   cnv_cmplt,
    input  logic [A2D_WIDTH-1:0]   A2D_res,
    output logic                   IR_in_en,
    output logic                   IR_mid_en,
    output logic                   IR_out_en,
    output logic [7:0]             LEDs,
    output logic [MOTOR_WIDTH-1:0] lft,
    output logic [MOTOR_WIDTH-1:0] rht
);

    logic pwm_on;
    logic loop_done;
    err_t error;

    sample_if u_smp ();

    sensor_seq u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .go        (go),
        .strt_cnv  (strt_cnv),
        .cnv_cmplt (cnv_cmplt),
        .A2D_res   (A2D_res),
        .chnnl     (chnnl),
        .pwm_on    (pwm_on),
        .loop_done (loop_done),
        .smp       (u_smp.src)
    );

    ir_pwm u_pwm (
        .clk       (clk),
        .rst_n     (rst_n),
        .pwm_on    (pwm_on),
        .chnnl     (chnnl),
        .IR_in_en  (IR_in_en),
        .IR_mid_en (IR_mid_en),
        .IR_out_en (IR_out_en)
    );

    error_accum u_acc (
        .clk   (clk),
        .rst_n (rst_n),
        .smp   (u_smp.dst),
        .error (error),
        .LEDs  (LEDs)
    );

    pi_ctrl u_pi (
        .clk       (clk),
        .rst_n     (rst_n),
        .go        (go),
        .loop_done (loop_done),
        .error     (error),
        .lft       (lft),
        .rht       (rht)
    );

endmodule

// ==== verification/a2d_model.sv ====
// behavioural A2D converter, answers each strt_cnv with a random latency of 4 to 20 cycles
// strobes alternate dummy and real, only real ones return the loop's reading
`timescale 1ns/1ps

module a2d_model (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             strt_cnv,
    input  logic [2:0]       chnnl,
    input  logic [5:0][11:0] readings,  // slot order 1, 0, 4, 2, 3, 7
    output logic             cnv_cmplt,
    output logic [11:0]      A2D_res
);

    integer     seed;
    integer     rnd;
    integer     lat;
    logic       real_cnv;
    logic [2:0] ch;

    function automatic int slot_of(input logic [2:0] c);
        case (c)
            3'd1:    return 0;
            3'd0:    return 1;
            3'd4:    return 2;
            3'd2:    return 3;
            3'd3:    return 4;
            default: return 5;
        endcase
    endfunction

    initial begin
        seed      = 32'hd7a;
        cnv_cmplt = 1'b1;
        A2D_res   = '0;
        real_cnv  = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                real_cnv = 1'b0;
            end else if (strt_cnv) begin
                ch = chnnl;
                #1 cnv_cmplt = 1'b0;
                rnd = $random(seed);
                lat = 4 + (((rnd % 17) + 17) % 17);
                repeat (lat - 1) @(posedge clk);
                #1;
                rnd = $random(seed);
                A2D_res   = real_cnv ? readings[slot_of(ch)] : rnd[11:0];  // garbage on dummy
                cnv_cmplt = 1'b1;
                real_cnv  = !real_cnv;
            end
        end
    end

endmodule

// ==== verification/tb_motion_ctrl.sv ====
// testbench for motion_ctrl, one vector line per control loop
// run from the project root so the vector file path resolves
`timescale 1ns/1ps

module tb_motion_ctrl;

    localparam int SETTLE_WAIT = 4096 + 1;
    localparam int MAX_VEC     = 32;

    logic             clk;
    logic             rst_n;
    logic             go;
    logic             strt_cnv;
    logic [2:0]       chnnl;
    logic             cnv_cmplt;
    logic [11:0]      A2D_res;
    logic             IR_in_en;
    logic             IR_mid_en;
    logic             IR_out_en;
    logic [7:0]       LEDs;
    logic [10:0]      lft;
    logic [10:0]      rht;
    logic [5:0][11:0] rd_bus;

    logic [11:0] vec_rd [MAX_VEC][6];
    logic [7:0]  vec_led [MAX_VEC];
    logic [10:0] vec_lft [MAX_VEC];
    logic [10:0] vec_rht [MAX_VEC];
    logic        vec_stop [MAX_VEC];
    int          nvec;
    int          n_checks;
    int          n_err;

    logic [2:0] ch_order [6] = '{3'd1, 3'd0, 3'd4, 3'd2, 3'd3, 3'd7};
    logic [2:0] seen_ch [$];
    logic [2:0] prev_ch;
    logic       ir_prev;
    logic       armed;
    logic       counting;
    int         settle_cnt;
    logic       ir_any;

    assign ir_any = IR_in_en | IR_mid_en | IR_out_en;

    motion_ctrl u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .go        (go),
        .strt_cnv  (strt_cnv),
        .chnnl     (chnnl),
        .cnv_cmplt (cnv_cmplt),
        .A2D_res   (A2D_res),
        .IR_in_en  (IR_in_en),
        .IR_mid_en (IR_mid_en),
        .IR_out_en (IR_out_en),
        .LEDs      (LEDs),
        .lft       (lft),
        .rht       (rht)
    );

    a2d_model u_a2d (
        .clk       (clk),
        .rst_n     (rst_n),
        .strt_cnv  (strt_cnv),
        .chnnl     (chnnl),
        .readings  (rd_bus),
        .cnv_cmplt (cnv_cmplt),
        .A2D_res   (A2D_res)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_hex(input string name, input logic [15:0] got, input logic [15:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_err++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        n_checks++;
        assert (cond) else begin
            n_err++;
            $display("%s at %0t", what, $time);
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    cnt;
        int    v [10];
        string line;
        fd = $fopen("verification/motion_ctrl_vectors.txt", "r");
        check_true(fd != 0, "vector file could not be opened");
        if (fd != 0) begin
            while (!$feof(fd) && nvec < MAX_VEC) begin
                line = "";
                void'($fgets(line, fd));
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                if (cnt == 10) begin  // comment and blank lines scan short
                    for (int k = 0; k < 6; k++)
                        vec_rd[nvec][k] = v[k][11:0];
                    vec_led[nvec]  = v[6][7:0];
                    vec_lft[nvec]  = v[7][10:0];
                    vec_rht[nvec]  = v[8][10:0];
                    vec_stop[nvec] = v[9][0];
                    nvec++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_idle_outputs();
        check_true(!ir_any, "IR enable high while the sequencer is idle");
        check_hex("lft", 16'(lft), 16'h0);
        check_hex("rht", 16'(rht), 16'h0);
    endtask

    // conversion order, settle time and pair gating
    always @(posedge clk) begin
        if (!rst_n) begin
            seen_ch.delete();
            prev_ch  = 3'd1;
            ir_prev  = 1'b0;
            armed    = 1'b1;
            counting = 1'b0;
        end else begin
            if (counting)
                settle_cnt++;
            if (chnnl != prev_ch && (chnnl == 3'd1 || chnnl == 3'd4 || chnnl == 3'd3))
                armed = 1'b1;
            if (armed && ir_any && !ir_prev) begin
                counting   = 1'b1;
                settle_cnt = 0;
                armed      = 1'b0;
            end
            if (strt_cnv) begin
                if (seen_ch.size() % 4 == 0) begin
                    check_true(counting, "first conversion of a pair had no IR enable rise before it");
                    if (counting)
                        check_hex("settle_cycles", 16'(settle_cnt), 16'(SETTLE_WAIT));
                    counting = 1'b0;
                end
                seen_ch.push_back(chnnl);
            end
            if (u_dut.loop_done) begin
                check_true(seen_ch.size() == 12, "loop did not hold exactly twelve conversions");
                for (int k = 0; k < seen_ch.size() && k < 12; k++)
                    check_hex("chnnl", 16'(seen_ch[k]), 16'(ch_order[k / 2]));
                seen_ch.delete();
            end
            if (IR_in_en)
                check_true(chnnl == 3'd1 || chnnl == 3'd0, "IR_in_en high outside the inner pair");
            if (IR_mid_en)
                check_true(chnnl == 3'd4 || chnnl == 3'd2, "IR_mid_en high outside the middle pair");
            if (IR_out_en)
                check_true(chnnl == 3'd3 || chnnl == 3'd7, "IR_out_en high outside the outer pair");
            ir_prev = ir_any;
            prev_ch = chnnl;
        end
    end

    initial begin
        go       = 1'b0;
        rst_n    = 1'b0;
        rd_bus   = '0;
        nvec     = 0;
        n_checks = 0;
        n_err    = 0;
        load_vectors();
        check_true(nvec > 0, "no vectors were read");
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        check_hex("LEDs", 16'(LEDs), 16'h0);
        check_hex("chnnl", 16'(chnnl), 16'h1);

        for (int i = 0; i < nvec; i++) begin
            for (int k = 0; k < 6; k++)
                rd_bus[k] = vec_rd[i][k];
            @(posedge clk);
            #1 go = 1'b1;
            if (vec_stop[i]) begin
                // drop go partway, the loop itself still runs to channel 7
                do @(posedge clk); while (!strt_cnv);
                #1 go = 1'b0;
            end
            do @(posedge clk); while (!u_dut.loop_done);
            repeat (10) @(posedge clk);
            @(negedge clk);
            check_hex("LEDs", 16'(LEDs), 16'(vec_led[i]));
            check_hex("lft", 16'(lft), 16'(vec_lft[i]));
            check_hex("rht", 16'(rht), 16'(vec_rht[i]));
            if (vec_stop[i]) begin
                repeat (6) begin
                    @(negedge clk);
                    check_idle_outputs();
                end
            end
        end

        $display("%0d vectors, %0d checks, %0d errors", nvec, n_checks, n_err);
        if (n_err == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // watchdog, 30000 cycles per loop
    initial begin
        wait (nvec > 0);
        repeat (nvec * 30000) @(posedge clk);
        $display("timeout waiting for the control loops to complete");
        $display("%0d vectors, %0d checks, %0d errors", nvec, n_checks, n_err);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== verification/motion_ctrl_vectors.txt ====
# readings in hex by channel: ch1 ch0 ch4 ch2 ch3 ch7, then expected LEDs lft rht
# last column 1 drops go during that loop, lft and rht then read 0
100 080 040 020 010 008 0e 0be 741 0
000 000 000 000 fff 000 7f 3ff 400 0
000 000 000 000 000 fff 80 400 3ff 0
000 200 000 000 000 000 e0 5ac 254 0
300 000 000 000 000 000 30 1ee 612 0
000 000 100 000 000 000 20 000 000 1
050 000 000 000 000 000 05 7a4 05c 0
000 000 000 000 000 040 f0 636 1ca 0
000 000 000 0c0 000 000 e8 5c9 237 0
400 000 000 000 000 000 40 278 588 0

// ==== motion_ctrl.f ====
src/sense_pkg.sv
src/pi_pkg.sv
src/sample_if.sv
src/sensor_seq.sv
src/ir_pwm.sv
src/error_accum.sv
src/pi_ctrl.sv
src/motion_ctrl.sv
verification/a2d_model.sv
verification/tb_motion_ctrl.sv

// ==== Makefile ====
# Verilator flow for the motion controller
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= motion_ctrl.f
TB_TOP    ?= tb_motion_ctrl
RTL_TOP   ?= motion_ctrl
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
